/* sources.f */
+incdir+bench
design/ks10Pkg.sv
design/phaseClock.sv
design/busArbiter.sv
design/memController.sv
design/ks10Top.sv
bench/ks10Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the KS10 backplane testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module ks10Tb -f sources.f --Mdir obj_dir -o Vks10Tb
./obj_dir/Vks10Tb 2>&1 | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* bench/ks10TbTasks.svh */
//////////////////////////////////////////////////////////////////////
// Drive, wait and compare tasks; expects the ks10Tb signal names.
//////////////////////////////////////////////////////////////////////

`ifndef KS10_TB_TASKS_SVH
`define KS10_TB_TASKS_SVH

task automatic haltRun();
   $display("ERRORS FOUND");
   $fatal(1, "Simulation stopped at first error");
endtask

task automatic nextCycle();
   @(posedge clk);
   #stimDelay;
endtask

task automatic applyReset();
   rst = 1'b1;
   nextCycle();
   nextCycle();
   rst = 1'b0;
endtask

function automatic word_t randWord();
   logic [31:0] hi;
   logic [31:0] lo;
   hi = $urandom();
   lo = $urandom();
   return {hi[3:0], lo};
endfunction

function automatic busResp_t makeResp(word_t data, logic nxm);
   busResp_t r;
   r.data = data;
   r.nxm  = nxm;
   return r;
endfunction

// Ring order T1, T2, T3, T4 counted from reset release
function automatic phase_t expectedPhase(int step);
   case (step % 4)
      0:       return phaseT1;
      1:       return phaseT2;
      2:       return phaseT3;
      default: return phaseT4;
   endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Request drivers, one strobe then one idle cycle for writes
//////////////////////////////////////////////////////////////////////

task automatic cslWrite(memAddr_t addr, word_t data);
   cslReq.op   = busWrite;
   cslReq.addr = addr;
   cslReq.data = data;
   cslReqStb   = 1'b1;
   nextCycle();
   cslReqStb   = 1'b0;
   nextCycle();                                // Keep strobe spacing
endtask

task automatic cslRead(memAddr_t addr);
   cslReq.op   = busRead;
   cslReq.addr = addr;
   cslReq.data = '0;
   cslReqStb   = 1'b1;
   nextCycle();
   cslReqStb   = 1'b0;
endtask

task automatic ubaWrite(memAddr_t addr, word_t data);
   ubaReq.op   = busWrite;
   ubaReq.addr = addr;
   ubaReq.data = data;
   ubaReqStb   = 1'b1;
   nextCycle();
   ubaReqStb   = 1'b0;
   nextCycle();
endtask

task automatic ubaRead(memAddr_t addr);
   ubaReq.op   = busRead;
   ubaReq.addr = addr;
   ubaReq.data = '0;
   ubaReqStb   = 1'b1;
   nextCycle();
   ubaReqStb   = 1'b0;
endtask

// Both masters strobe in the same cycle
task automatic dualRead(memAddr_t cAddr, memAddr_t uAddr);
   cslReq.op   = busRead;
   cslReq.addr = cAddr;
   cslReq.data = '0;
   ubaReq.op   = busRead;
   ubaReq.addr = uAddr;
   ubaReq.data = '0;
   cslReqStb   = 1'b1;
   ubaReqStb   = 1'b1;
   nextCycle();
   cslReqStb   = 1'b0;
   ubaReqStb   = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// Response wait, other port must stay quiet
//////////////////////////////////////////////////////////////////////

task automatic waitResp(busMaster_t port, output int cycles, output busResp_t got);
   logic  seen;
   string who;
   seen   = 1'b0;
   cycles = 0;
   who    = (port == mstCsl) ? "console" : "adapter";
   while (!seen && cycles < respTimeout)
   begin
      nextCycle();
      cycles++;
      if (port == mstCsl)
      begin
         seen = cslRespStb;
         got  = cslResp;
         checkBit("ubaRespStb", 1'b0, ubaRespStb);
      end
      else
      begin
         seen = ubaRespStb;
         got  = ubaResp;
         checkBit("cslRespStb", 1'b0, cslRespStb);
      end
   end
   if (!seen)
   begin
      $display("TIMEOUT at %0t: the %s read response never arrived within %0d cycles",
               $time, who, respTimeout);
      haltRun();
   end
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic checkResp(string name, busResp_t exp, busResp_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED at %0t: %s expected data=%h nxm=%b, actual data=%h nxm=%b",
               $time, name, exp.data, exp.nxm, act.data, act.nxm);
      haltRun();
   end
endtask

task automatic checkPhase(string name, phase_t exp, phase_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED at %0t: %s expected %s (%b), actual %s (%b)",
               $time, name, exp.name(), exp, act.name(), act);
      haltRun();
   end
endtask

task automatic checkBit(string name, logic exp, logic act);
   if (act !== exp)
   begin
      $display("CHECK FAILED at %0t: %s expected %b, actual %b", $time, name, exp, act);
      haltRun();
   end
endtask

task automatic checkCount(string name, int exp, int act);
   if (act != exp)
   begin
      $display("CHECK FAILED at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
      haltRun();
   end
endtask

`endif

/* bench/ks10Tb.sv */
//////////////////////////////////////////////////////////////////////
// Directed tests for the backplane core with 256 words of memory.
// Read drivers spend the strobe cycle before a response wait starts.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ks10Tb
   import ks10Pkg::*;
();

   localparam int stimDelay   = 10;          // Input drive offset after the edge
   localparam int respTimeout = 10;          // Cycles allowed for a read response

   logic     clk;
   logic     rst;
   logic     cslReqStb;
   busReq_t  cslReq;
   logic     ubaReqStb;
   busReq_t  ubaReq;
   logic     cslRespStb;
   busResp_t cslResp;
   logic     ubaRespStb;
   busResp_t ubaResp;
   phase_t   phase;
   logic     cpuClk;
   logic     cslRst;

   // Test addresses and the words written there
   memAddr_t cslAddr = 20'h00000;
   memAddr_t ubaAddr = 20'h000A5;
   word_t    cslWord;
   word_t    ubaWord;

   ks10Top #(
      .memWords   (256)
   ) ks10Top_inst (
      .clk        (clk),
      .rst        (rst),
      .cslReqStb  (cslReqStb),
      .cslReq     (cslReq),
      .cslRespStb (cslRespStb),
      .cslResp    (cslResp),
      .ubaReqStb  (ubaReqStb),
      .ubaReq     (ubaReq),
      .ubaRespStb (ubaRespStb),
      .ubaResp    (ubaResp),
      .phase      (phase),
      .cpuClk     (cpuClk),
      .cslRst     (cslRst)
   );

   always #50 clk = ~clk;

   `include "ks10TbTasks.svh"

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic phaseTest();
      phase_t expPhase;
      checkPhase("phase", phaseT1, phase);
      checkBit("cslRst", 1'b1, cslRst);
      for (int k = 1; k <= 12; k++)
      begin
         nextCycle();
         expPhase = expectedPhase(k);
         checkPhase("phase", expPhase, phase);
         checkBit("cpuClk", (expPhase == phaseT1) || (expPhase == phaseT2), cpuClk);
         checkBit("cslRst", k < 4, cslRst);      // Falls on the 4th edge
      end
   endtask

   task automatic consoleTest();
      int       cycles;
      busResp_t got;
      applyReset();
      cslRead(cslAddr);                        // Dropped while the console is in reset
      for (int k = 0; k < 6; k++)
      begin
         nextCycle();
         checkBit("cslRespStb", 1'b0, cslRespStb);
         checkBit("ubaRespStb", 1'b0, ubaRespStb);
      end
      cslWord = randWord();
      cslWrite(cslAddr, cslWord);
      cslRead(cslAddr);
      waitResp(mstCsl, cycles, got);
      checkCount("cslRespStb latency", 2, cycles + 1);
      checkResp("cslResp", makeResp(cslWord, 1'b0), got);
   endtask

   task automatic adapterTest();
      int       cycles;
      busResp_t got;
      ubaWord = randWord();
      ubaWrite(ubaAddr, ubaWord);
      ubaRead(ubaAddr);
      waitResp(mstUba, cycles, got);
      checkCount("ubaRespStb latency", 2, cycles + 1);
      checkResp("ubaResp", makeResp(ubaWord, 1'b0), got);
      // Console word must survive the adapter write
      cslRead(cslAddr);
      waitResp(mstCsl, cycles, got);
      checkCount("cslRespStb latency", 2, cycles + 1);
      checkResp("cslResp", makeResp(cslWord, 1'b0), got);
   endtask

   task automatic contentionTest();
      int       cslCycles;
      int       ubaCycles;
      busResp_t got;
      dualRead(cslAddr, ubaAddr);
      waitResp(mstCsl, cslCycles, got);
      checkCount("cslRespStb latency", 2, cslCycles + 1);
      checkResp("cslResp", makeResp(cslWord, 1'b0), got);
      waitResp(mstUba, ubaCycles, got);        // Loser served one cycle later
      checkCount("ubaRespStb latency", 3, 1 + cslCycles + ubaCycles);
      checkResp("ubaResp", makeResp(ubaWord, 1'b0), got);
   endtask

   task automatic nxmTest();
      int       cycles;
      busResp_t got;
      cslRead(20'd256);
      waitResp(mstCsl, cycles, got);
      checkResp("cslResp", makeResp('0, 1'b1), got);
      ubaRead(20'hFFFFF);
      waitResp(mstUba, cycles, got);
      checkResp("ubaResp", makeResp('0, 1'b1), got);
      // 256 aliases index 0 if the decode is wrong
      cslWrite(20'd256, randWord());
      cslRead(cslAddr);
      waitResp(mstCsl, cycles, got);
      checkResp("cslResp", makeResp(cslWord, 1'b0), got);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      clk       = 1'b0;
      rst       = 1'b1;
      cslReqStb = 1'b0;
      cslReq    = '0;
      ubaReqStb = 1'b0;
      ubaReq    = '0;
      void'($urandom(32'h192));
      applyReset();
      phaseTest();
      consoleTest();
      adapterTest();
      contentionTest();
      nxmTest();
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

/* design/ks10Top.sv */
//////////////////////////////////////////////////////////////////////
// Backplane core: phase generator, arbiter and word memory.
// Masters use one-cycle strobes with no back-pressure.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ks10Top
   import ks10Pkg::*;
#(
   parameter int memWords = 1024              // Implemented memory words
)
(
   input  logic       clk,
   input  logic       rst,
   // Console port
   input  logic       cslReqStb,
   input  busReq_t    cslReq,
   output logic       cslRespStb,
   output busResp_t   cslResp,
   // Unibus adapter port
   input  logic       ubaReqStb,
   input  busReq_t    ubaReq,
   output logic       ubaRespStb,
   output busResp_t   ubaResp,
   // Clock phases
   output phase_t     phase,
   output logic       cpuClk,
   output logic       cslRst
);

   // Arbiter to memory
   logic       memReqStb;
   busReq_t    memReq;
   busMaster_t memMaster;

   // Memory back to arbiter
   logic       respStb;
   busResp_t   resp;
   busMaster_t respMaster;

   //////////////////////////////////////////////////////////////////////
   // Phase ring
   //////////////////////////////////////////////////////////////////////

   phaseClock phaseClock_inst (
      .clk        (clk),
      .rst        (rst),
      .phase      (phase),
      .cpuClk     (cpuClk),
      .cslRst     (cslRst)
   );

   //////////////////////////////////////////////////////////////////////
   // Arbitration and memory
   //////////////////////////////////////////////////////////////////////

   busArbiter busArbiter_inst (
      .clk        (clk),
      .rst        (rst),
      .cslRst     (cslRst),
      .cslReqStb  (cslReqStb),
      .cslReq     (cslReq),
      .ubaReqStb  (ubaReqStb),
      .ubaReq     (ubaReq),
      .memReqStb  (memReqStb),
      .memReq     (memReq),
      .memMaster  (memMaster),
      .respStb    (respStb),
      .resp       (resp),
      .respMaster (respMaster),
      .cslRespStb (cslRespStb),
      .cslResp    (cslResp),
      .ubaRespStb (ubaRespStb),
      .ubaResp    (ubaResp)
   );

   memController #(
      .memWords   (memWords)
   ) memController_inst (
      .clk        (clk),
      .rst        (rst),
      .memReqStb  (memReqStb),
      .memReq     (memReq),
      .memMaster  (memMaster),
      .respStb    (respStb),
      .resp       (resp),
      .respMaster (respMaster)
   );

endmodule

`default_nettype wire

/* design/memController.sv */
//////////////////////////////////////////////////////////////////////
// Word memory of memWords entries starting at address 0. Writes above
// the top are dropped; reads there return zero with nxm.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module memController
   import ks10Pkg::*;
#(
   parameter int memWords = 1024
)
(
   input  logic       clk,
   input  logic       rst,
   // Granted request
   input  logic       memReqStb,
   input  busReq_t    memReq,
   input  busMaster_t memMaster,
   // Read response
   output logic       respStb,
   output busResp_t   resp,
   output busMaster_t respMaster
);

   localparam int idxWidth = $clog2(memWords);

   word_t                mem [memWords];    // No reset, contents undefined
   logic [idxWidth-1:0]  memIdx;
   logic                 nxm;
   logic                 doWrite;
   logic                 doRead;

   //////////////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////////////

   // Anything at or above the top is nonexistent
   assign nxm     = int'(memReq.addr) >= memWords;
   assign memIdx  = memReq.addr[idxWidth-1:0];
   assign doWrite = memReqStb & (memReq.op == busWrite) & ~nxm;
   assign doRead  = memReqStb & (memReq.op == busRead);

   //////////////////////////////////////////////////////////////////////
   // Array
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (doWrite)
      begin
         mem[memIdx] <= memReq.data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read response
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         respStb <= 1'b0;
      end
      else
      begin
         respStb <= doRead;               // Writes are not acknowledged
      end
   end

   // Payload, only meaningful with respStb
   always_ff @(posedge clk)
   begin
      if (doRead)
      begin
         resp.nxm   <= nxm;
         respMaster <= memMaster;
         if (nxm)
         begin
            resp.data <= '0;
         end
         else
         begin
            resp.data <= mem[memIdx];
         end
      end
   end

endmodule

`default_nettype wire

/* design/busArbiter.sv */
//////////////////////////////////////////////////////////////////////
// Fixed priority: pending, then console, then adapter. The one-entry
// slot relies on each master strobing at most every other cycle.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module busArbiter
   import ks10Pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       cslRst,
   // Requests
   input  logic       cslReqStb,
   input  busReq_t    cslReq,
   input  logic       ubaReqStb,
   input  busReq_t    ubaReq,
   // Toward memory
   output logic       memReqStb,
   output busReq_t    memReq,
   output busMaster_t memMaster,
   // From memory
   input  logic       respStb,
   input  busResp_t   resp,
   input  busMaster_t respMaster,
   // Responses
   output logic       cslRespStb,
   output busResp_t   cslResp,
   output logic       ubaRespStb,
   output busResp_t   ubaResp
);

   logic       cslValid;                 // Console strobe past the reset filter

   // Deferred request slot
   logic       pendValid;
   busReq_t    pendReq;
   busMaster_t pendMaster;

   // This cycle's decision
   logic       grantValid;
   busReq_t    grantReq;
   busMaster_t grantMaster;
   logic       parkValid;
   busReq_t    parkReq;
   busMaster_t parkMaster;

   assign cslValid = cslReqStb & ~cslRst;

   //////////////////////////////////////////////////////////////////////
   // Grant selection
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      grantValid  = 1'b0;
      grantReq    = pendReq;
      grantMaster = pendMaster;
      parkValid   = 1'b0;
      parkReq     = ubaReq;
      parkMaster  = mstUba;

      if (pendValid)
      begin
         // Old loser goes first, any new strobe takes the freed slot
         grantValid = 1'b1;
         if (cslValid)
         begin
            parkValid  = 1'b1;
            parkReq    = cslReq;
            parkMaster = mstCsl;
         end
         else if (ubaReqStb)
         begin
            parkValid = 1'b1;
         end
      end
      else if (cslValid)
      begin
         grantValid  = 1'b1;
         grantReq    = cslReq;
         grantMaster = mstCsl;
         parkValid   = ubaReqStb;          // Adapter lost the contest
      end
      else if (ubaReqStb)
      begin
         grantValid  = 1'b1;
         grantReq    = ubaReq;
         grantMaster = mstUba;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registered grant and slot
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         memReqStb <= 1'b0;
         pendValid <= 1'b0;
      end
      else
      begin
         memReqStb <= grantValid;
         pendValid <= parkValid;
      end
   end

   always_ff @(posedge clk)
   begin
      memReq     <= grantReq;
      memMaster  <= grantMaster;
      pendReq    <= parkReq;
      pendMaster <= parkMaster;
   end

   //////////////////////////////////////////////////////////////////////
   // Response routing
   //////////////////////////////////////////////////////////////////////

   // Strobe goes to the tagged master, data is shared
   assign cslRespStb = respStb & (respMaster == mstCsl);
   assign ubaRespStb = respStb & (respMaster == mstUba);
   assign cslResp    = resp;
   assign ubaResp    = resp;

endmodule

`default_nettype wire

/* design/phaseClock.sv */
//////////////////////////////////////////////////////////////////////
// T1..T4 phase ring on the system clock. cslRst holds through the
// first full phase cycle after reset.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module phaseClock
   import ks10Pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   output phase_t phase,
   output logic   cpuClk,
   output logic   cslRst
);

   //////////////////////////////////////////////////////////////////////
   // Phase ring and console reset
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phase  <= phaseT1;
         cslRst <= 1'b1;
      end
      else
      begin
         case (phase)
            phaseT1: phase <= phaseT2;
            phaseT2: phase <= phaseT3;
            phaseT3: phase <= phaseT4;
            phaseT4:
            begin
               phase  <= phaseT1;
               cslRst <= 1'b0;         // First full cycle done
            end
            default: phase <= phaseT1;  // Recover from a bad encoding
         endcase
      end
   end

   // High in T1 and T2
   assign cpuClk = phase[3];

endmodule

`default_nettype wire

/* design/ks10Pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared bus types for the backplane core. Word and address widths
// are fixed at 36 and 20 bits; only two bus masters are encoded.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ks10Pkg;

   //////////////////////////////////////////////////////////////////////
   // Data and address
   //////////////////////////////////////////////////////////////////////

   // One KS10 data word, bit 0 of the KS10 numbering is bit 35 here
   typedef logic [35:0] word_t;

   localparam int addrWidth = 20;             // Physical address width

   typedef logic [addrWidth-1:0] memAddr_t;   // Physical word address

   //////////////////////////////////////////////////////////////////////
   // Bus opcodes and requesters
   //////////////////////////////////////////////////////////////////////

   typedef enum logic
   {
      busRead  = 1'b0,
      busWrite = 1'b1
   } busOp_t;

   // Requester tag, carried with each grant and its response
   typedef enum logic
   {
      mstCsl = 1'b0,                          // Console
      mstUba = 1'b1                           // Unibus adapter
   } busMaster_t;

   //////////////////////////////////////////////////////////////////////
   // Request and response
   //////////////////////////////////////////////////////////////////////

   typedef struct packed
   {
      busOp_t   op;                           // Read or write
      memAddr_t addr;
      word_t    data;                         // Write data, ignored on reads
   } busReq_t;

   typedef struct packed
   {
      word_t data;                            // Zero on nxm
      logic  nxm;                             // Nonexistent memory
   } busResp_t;

   //////////////////////////////////////////////////////////////////////
   // Clock phases
   //////////////////////////////////////////////////////////////////////

   // Two adjacent bits high per phase, rotating right each step.
   // The top bit is the CPU clock.
   typedef enum logic [3:0]
   {
      phaseT1 = 4'b1001,
      phaseT2 = 4'b1100,
      phaseT3 = 4'b0110,
      phaseT4 = 4'b0011
   } phase_t;

endpackage

`default_nettype wire
